/* ptr_alloc.f */
hdl/ptr_alloc_pkg.sv
hdl/ptr_fifo.sv
hdl/bitmap_ram.sv
hdl/free_scanner.sv
hdl/bitmap_updater.sv
hdl/ptr_alloc_top.sv
bench/ptr_alloc_tb.sv

/* Makefile */
# Verilator build and run for the pointer allocator testbench

VERILATOR ?= verilator
TOP       ?= ptr_alloc_tb
FILELIST  ?= ptr_alloc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.DEFAULT_GOAL := help
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/ptr_alloc_tb.sv */
// Testbench for the pointer allocator with reference bitmap, assertions and timeout
`timescale 1ns/1ps

module ptr_alloc_tb;
    import ptr_alloc_pkg::*;

    localparam int fifo_depth  = 32;
    localparam int reuse_cnt   = 40;
    // 256 allocations at about 8 cycles, doubled, plus reuse and double free
    localparam int cycle_limit = 20000;

    logic        clk = 1'b0;
    logic        local_srst;
    logic        en;
    logic        init_done;
    logic        alloc_valid;
    logic        alloc_ready;
    ptr_t        alloc_ptr;
    logic        dealloc_valid;
    logic        dealloc_ready;
    ptr_t        dealloc_ptr;
    err_report_t err;

    // Reference model and bookkeeping
    logic [num_ptrs-1:0] held = '0;
    int          xfer_cnt    = 0;
    int          dq_xfer_cnt = 0;
    int          derr_cnt    = 0;
    int          cycle_cnt   = 0;
    int          value_errs  = 0;
    int          proto_errs  = 0;
    integer      seed;
    ptr_t        prev_alloc_ptr;
    ptr_t        pending_ptr;
    ptr_t        dfree_ptr;
    logic        consume      = 1'b0;
    logic        empty_chk    = 1'b0;
    logic        resume_armed = 1'b0;
    logic        dfree_armed  = 1'b0;
    logic        final_chk    = 1'b0;
    string       phase        = "reset";
    ptr_t        free_list[$];

    always #2 clk = ~clk;

    ptr_alloc_top #(.fifo_depth(fifo_depth)) dut0 (
        .clk           (clk),
        .local_srst    (local_srst),
        .en            (en),
        .init_done     (init_done),
        .alloc_valid   (alloc_valid),
        .alloc_ready   (alloc_ready),
        .alloc_ptr     (alloc_ptr),
        .dealloc_valid (dealloc_valid),
        .dealloc_ready (dealloc_ready),
        .dealloc_ptr   (dealloc_ptr),
        .err           (err)
    );

    // ------------------------------
    // Consumer with random stalls
    // ------------------------------
    always @(posedge clk) begin
        logic use_rand;
        use_rand = consume;
        #1;
        alloc_ready = use_rand ? (($random(seed) & 3) != 0) : 1'b0;
    end

    // Transfer monitor, updates the model bitmap
    always @(posedge clk) begin
        prev_alloc_ptr <= alloc_ptr;
        if (alloc_valid && alloc_ready) begin
            held[alloc_ptr] <= 1'b1;
            xfer_cnt        <= xfer_cnt + 1;
        end
        if (dealloc_valid && dealloc_ready) begin
            held[dealloc_ptr] <= 1'b0;
            dq_xfer_cnt       <= dq_xfer_cnt + 1;
        end
        if (err.dealloc_err) begin
            derr_cnt <= derr_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == cycle_limit) begin
            $display("Timeout after %0d cycles in phase %s", cycle_limit, phase);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Assertions
    // ------------------------------
    a_reset_quiet: assert property (@(posedge clk)
        !init_done |-> !alloc_valid && !dealloc_ready && !err.alloc_err && !err.dealloc_err)
        else begin
            proto_errs++;
            $display("reset: a port or error flag was active before init_done");
        end

    a_first_order: assert property (@(posedge clk) disable iff (local_srst)
        (alloc_valid && alloc_ready && xfer_cnt < num_ptrs) |-> alloc_ptr == ptr_t'(xfer_cnt))
        else begin
            value_errs++;
            $display("** Error first_pass: expected %0d, actual %0d",
                     $sampled(xfer_cnt), $sampled(alloc_ptr));
        end

    a_hold_stable: assert property (@(posedge clk) disable iff (local_srst)
        (alloc_valid && !alloc_ready) |=> alloc_ptr == prev_alloc_ptr)
        else begin
            value_errs++;
            $display("** Error hold_stable: expected %0d, actual %0d",
                     $sampled(prev_alloc_ptr), $sampled(alloc_ptr));
        end

    a_valid_kept: assert property (@(posedge clk) disable iff (local_srst)
        (alloc_valid && !alloc_ready) |=> (alloc_valid || !en))
        else begin
            proto_errs++;
            $display("alloc_valid fell without a transfer while enabled");
        end

    a_alloc_free: assert property (@(posedge clk) disable iff (local_srst)
        (alloc_valid && alloc_ready) |-> !held[alloc_ptr])
        else begin
            proto_errs++;
            $display("reuse: pointer %0d handed out while still held", $sampled(alloc_ptr));
        end

    a_empty_pool: assert property (@(posedge clk) disable iff (local_srst)
        empty_chk |-> !alloc_valid)
        else begin
            proto_errs++;
            $display("empty_pool: alloc_valid rose with every pointer held");
        end

    a_dfree_ptr: assert property (@(posedge clk) disable iff (local_srst)
        err.dealloc_err |-> err.ptr == dfree_ptr)
        else begin
            value_errs++;
            $display("** Error double_free: expected %0d, actual %0d",
                     $sampled(dfree_ptr), $sampled(err.ptr));
        end

    a_dfree_once: assert property (@(posedge clk) disable iff (local_srst)
        err.dealloc_err |-> dfree_armed && derr_cnt == 0)
        else begin
            proto_errs++;
            $display("double_free: unexpected dealloc error pulse");
        end

    a_no_alloc_err: assert property (@(posedge clk) disable iff (local_srst)
        !err.alloc_err)
        else begin
            proto_errs++;
            $display("alloc_err was set");
        end

    a_enable_low: assert property (@(posedge clk) disable iff (local_srst)
        !en |-> !alloc_valid && !dealloc_ready)
        else begin
            proto_errs++;
            $display("enable_low: a port handshake was open while en was low");
        end

    a_enable_resume: assert property (@(posedge clk) disable iff (local_srst)
        (resume_armed && $rose(en)) |-> alloc_valid && alloc_ptr == pending_ptr)
        else begin
            value_errs++;
            $display("** Error enable_resume: expected %0d, actual %0d",
                     $sampled(pending_ptr), $sampled(alloc_ptr));
        end

    a_final_held: assert property (@(posedge clk) disable iff (local_srst)
        final_chk |-> ($countones(held) == num_ptrs && derr_cnt == 1))
        else begin
            value_errs++;
            $display("** Error final: expected %0d held and 1 error pulse, actual %0d and %0d",
                     num_ptrs, $countones(held), derr_cnt);
        end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_xfers(input int target);
        while (xfer_cnt < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Consumer stops drawing random numbers from the next edge on
    task automatic stop_consumer();
        consume = 1'b0;
        wait_cycles(1);
    endtask

    task automatic free_ptr(input ptr_t p);
        int start;
        start         = dq_xfer_cnt;
        dealloc_valid = 1'b1;
        dealloc_ptr   = p;
        while (dq_xfer_cnt == start) begin
            @(posedge clk);
            #1;
        end
        dealloc_valid = 1'b0;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        logic [num_ptrs-1:0] picked;
        ptr_t                p;
        seed          = 32'h3bf5;
        local_srst    = 1'b1;
        en            = 1'b1;
        alloc_ready   = 1'b0;
        dealloc_valid = 1'b0;
        dealloc_ptr   = '0;
        repeat (4) @(posedge clk);
        #1;
        local_srst = 1'b0;

        phase = "waiting for init_done";
        while (!init_done) wait_cycles(1);

        // Hold the first pointer pending across a disabled stretch
        phase = "enable_low";
        while (!alloc_valid) wait_cycles(1);
        // Ascending order makes the pending pointer equal the transfer count
        pending_ptr = ptr_t'(xfer_cnt);
        en          = 1'b0;
        wait_cycles(20);
        resume_armed = 1'b1;
        en           = 1'b1;
        wait_cycles(1);
        resume_armed = 1'b0;

        phase   = "first_pass";
        consume = 1'b1;
        wait_xfers(num_ptrs);

        phase     = "empty_pool";
        empty_chk = 1'b1;
        wait_cycles(200);
        empty_chk = 1'b0;

        phase = "reuse";
        stop_consumer();
        picked = '0;
        repeat (reuse_cnt) begin
            p = ptr_t'($random(seed));
            while (picked[p]) p = p + 1'b1;
            picked[p] = 1'b1;
            free_list.push_back(p);
        end
        consume = 1'b1;
        foreach (free_list[i]) free_ptr(free_list[i]);
        wait_xfers(num_ptrs + reuse_cnt);

        // Second free of the same pointer lands while it is still free
        phase = "double_free";
        stop_consumer();
        dfree_ptr   = ptr_t'($random(seed));
        dfree_armed = 1'b1;
        free_ptr(dfree_ptr);
        free_ptr(dfree_ptr);
        consume = 1'b1;
        while (derr_cnt == 0) wait_cycles(1);
        wait_xfers(num_ptrs + reuse_cnt + 1);

        phase     = "final";
        final_chk = 1'b1;
        wait_cycles(1);
        final_chk = 1'b0;
        wait_cycles(1);

        $display("Summary: %0d value errors, %0d protocol errors, %0d allocations",
                 value_errs, proto_errs, xfer_cnt);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : ptr_alloc_tb

/* hdl/ptr_alloc_top.sv */
// Pointer allocator top with queues, bitmap RAM, scanner, updater and enable gating
`timescale 1ns/1ps

module ptr_alloc_top #(
    parameter int fifo_depth = 32
) (
    input  logic                       clk,
    input  logic                       local_srst,
    input  logic                       en,
    output logic                       init_done,
    output logic                       alloc_valid,
    input  logic                       alloc_ready,
    output ptr_alloc_pkg::ptr_t        alloc_ptr,
    input  logic                       dealloc_valid,
    output logic                       dealloc_ready,
    input  ptr_alloc_pkg::ptr_t        dealloc_ptr,
    output ptr_alloc_pkg::err_report_t err
);
    import ptr_alloc_pkg::*;

    logic      port_en;
    logic      aq_valid;
    logic      aq_ready;
    logic      aq_out_valid;
    ptr_t      aq_ptr;
    logic      dq_in_ready;
    logic      dq_valid;
    logic      dq_ready;
    ptr_t      dq_ptr;
    logic      cand_valid;
    logic      cand_take;
    ptr_addr_t cand;
    logic      upd_rd_req;
    logic      upd_rd_gnt;
    logic      upd_rd_ack;
    row_t      upd_rd_row;
    logic      scan_rd_req;
    logic      scan_rd_gnt;
    logic      scan_rd_ack;
    row_t      scan_rd_row;
    row_vec_t  rd_data;
    logic      wr_req;
    row_t      wr_row;
    row_vec_t  wr_data;

    // External ports closed while disabled or still sweeping
    assign port_en       = en && init_done;
    assign alloc_valid   = aq_out_valid && port_en;
    assign dealloc_ready = dq_in_ready && port_en;

    ptr_fifo #(.fifo_depth(fifo_depth)) alloc_q (
        .clk        (clk),
        .local_srst (local_srst),
        .in_valid   (aq_valid),
        .in_data    (aq_ptr),
        .in_ready   (aq_ready),
        .out_valid  (aq_out_valid),
        .out_data   (alloc_ptr),
        .out_ready  (alloc_ready && port_en)
    );

    ptr_fifo #(.fifo_depth(fifo_depth)) dealloc_q (
        .clk        (clk),
        .local_srst (local_srst),
        .in_valid   (dealloc_valid && port_en),
        .in_data    (dealloc_ptr),
        .in_ready   (dq_in_ready),
        .out_valid  (dq_valid),
        .out_data   (dq_ptr),
        .out_ready  (dq_ready)
    );

    bitmap_ram ram (
        .clk         (clk),
        .local_srst  (local_srst),
        .init_done   (init_done),
        .upd_rd_req  (upd_rd_req),
        .upd_rd_row  (upd_rd_row),
        .upd_rd_gnt  (upd_rd_gnt),
        .upd_rd_ack  (upd_rd_ack),
        .scan_rd_req (scan_rd_req),
        .scan_rd_row (scan_rd_row),
        .scan_rd_gnt (scan_rd_gnt),
        .scan_rd_ack (scan_rd_ack),
        .rd_data     (rd_data),
        .wr_req      (wr_req),
        .wr_row      (wr_row),
        .wr_data     (wr_data)
    );

    free_scanner scanner (
        .clk        (clk),
        .local_srst (local_srst),
        .init_done  (init_done),
        .rd_req     (scan_rd_req),
        .rd_row     (scan_rd_row),
        .rd_gnt     (scan_rd_gnt),
        .rd_ack     (scan_rd_ack),
        .rd_data    (rd_data),
        .cand_valid (cand_valid),
        .cand       (cand),
        .cand_take  (cand_take)
    );

    bitmap_updater updater (
        .clk        (clk),
        .local_srst (local_srst),
        .init_done  (init_done),
        .dq_valid   (dq_valid),
        .dq_ptr     (dq_ptr),
        .dq_ready   (dq_ready),
        .cand_valid (cand_valid),
        .cand       (cand),
        .cand_take  (cand_take),
        .aq_valid   (aq_valid),
        .aq_ptr     (aq_ptr),
        .aq_ready   (aq_ready),
        .rd_req     (upd_rd_req),
        .rd_row     (upd_rd_row),
        .rd_gnt     (upd_rd_gnt),
        .rd_ack     (upd_rd_ack),
        .rd_data    (rd_data),
        .wr_req     (wr_req),
        .wr_row     (wr_row),
        .wr_data    (wr_data),
        .err        (err)
    );

endmodule : ptr_alloc_top

/* hdl/bitmap_updater.sv */
// Read-modify-write FSM for deallocations and allocations with error detection
`timescale 1ns/1ps

module bitmap_updater (
    input  logic                       clk,
    input  logic                       local_srst,
    input  logic                       init_done,
    input  logic                       dq_valid,
    input  ptr_alloc_pkg::ptr_t        dq_ptr,
    output logic                       dq_ready,
    input  logic                       cand_valid,
    input  ptr_alloc_pkg::ptr_addr_t   cand,
    output logic                       cand_take,
    output logic                       aq_valid,
    output ptr_alloc_pkg::ptr_t        aq_ptr,
    input  logic                       aq_ready,
    output logic                       rd_req,
    output ptr_alloc_pkg::row_t        rd_row,
    input  logic                       rd_gnt,
    input  logic                       rd_ack,
    input  ptr_alloc_pkg::row_vec_t    rd_data,
    output logic                       wr_req,
    output ptr_alloc_pkg::row_t        wr_row,
    output ptr_alloc_pkg::row_vec_t    wr_data,
    output ptr_alloc_pkg::err_report_t err
);
    import ptr_alloc_pkg::*;

    typedef enum logic [3:0] {
        u_reset,
        u_idle,
        u_dealloc,
        u_alloc,
        u_rd_req,
        u_rd_wait,
        u_modify,
        u_write,
        u_done,
        u_error
    } upd_state_t;

    upd_state_t state;
    upd_state_t nxt_state;
    logic       op_dealloc;
    ptr_addr_t  new_addr;
    ptr_addr_t  op_addr;
    row_vec_t   col_mask;
    row_vec_t   row_q;
    logic       bit_match;

    always_ff @(posedge clk) begin
        if (local_srst) begin
            state <= u_reset;
        end else begin
            state <= nxt_state;
        end
    end

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        nxt_state = state;
        case (state)
            u_reset: if (init_done) nxt_state = u_idle;
            u_idle: begin
                // Deallocations first
                if (dq_valid) begin
                    nxt_state = u_dealloc;
                end else if (cand_valid && aq_ready) begin
                    nxt_state = u_alloc;
                end
            end
            u_dealloc, u_alloc: nxt_state = u_rd_req;
            u_rd_req:  if (rd_gnt) nxt_state = u_rd_wait;
            u_rd_wait: if (rd_ack) nxt_state = u_modify;
            u_modify:  nxt_state = bit_match ? u_error : u_write;
            u_write:   nxt_state = u_done;
            u_done, u_error: nxt_state = u_idle;
            default:   nxt_state = u_reset;
        endcase
    end

    // Operation latch
    always_ff @(posedge clk) begin
        if (local_srst) begin
            op_dealloc <= 1'b0;
        end else if (state == u_dealloc) begin
            op_dealloc <= 1'b1;
        end else if (state == u_alloc) begin
            op_dealloc <= 1'b0;
        end
    end

    assign new_addr = (state == u_dealloc) ? ptr_addr_t'(dq_ptr) : cand;

    always_ff @(posedge clk) begin
        if (state == u_dealloc || state == u_alloc) begin
            op_addr  <= new_addr;
            col_mask <= row_vec_t'(1) << new_addr.col;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ack) begin
            row_q <= rd_data;
        end
    end

    // Bit already at its target value
    assign bit_match = ((row_q & col_mask) != '0) == op_dealloc;

    always_ff @(posedge clk) begin
        if (state == u_modify) begin
            wr_data <= op_dealloc ? (row_q | col_mask) : (row_q & ~col_mask);
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign dq_ready        = (state == u_dealloc);
    assign cand_take       = (state == u_alloc);
    assign aq_valid        = (state == u_done) && !op_dealloc;
    assign aq_ptr          = ptr_t'(op_addr);
    assign rd_req          = (state == u_rd_req);
    assign rd_row          = op_addr.row;
    assign wr_req          = (state == u_write);
    assign wr_row          = op_addr.row;
    assign err.alloc_err   = (state == u_error) && !op_dealloc;
    assign err.dealloc_err = (state == u_error) && op_dealloc;
    assign err.ptr         = ptr_t'(op_addr);

    // Scanner only offers bits that are free in RAM
    a_no_alloc_err: assert property (@(posedge clk) disable iff (local_srst)
        !err.alloc_err)
        else $error("allocation of pointer %0d already in use", err.ptr);

    // Queue room checked at take time still holds at push time
    a_aq_room: assert property (@(posedge clk) disable iff (local_srst)
        aq_valid |-> aq_ready)
        else $error("allocation queue full at push");

endmodule : bitmap_updater

/* hdl/free_scanner.sv */
// Row scanner offering the lowest free pointer of each row in ascending order
`timescale 1ns/1ps

module free_scanner (
    input  logic                     clk,
    input  logic                     local_srst,
    input  logic                     init_done,
    output logic                     rd_req,
    output ptr_alloc_pkg::row_t      rd_row,
    input  logic                     rd_gnt,
    input  logic                     rd_ack,
    input  ptr_alloc_pkg::row_vec_t  rd_data,
    output logic                     cand_valid,
    output ptr_alloc_pkg::ptr_addr_t cand,
    input  logic                     cand_take
);
    import ptr_alloc_pkg::*;

    typedef enum logic [2:0] {
        s_reset,
        s_idle,
        s_rd_req,
        s_rd_wait,
        s_check,
        s_next,
        s_offer
    } scan_state_t;

    scan_state_t state;
    scan_state_t nxt_state;
    row_t        row;
    row_vec_t    row_copy;
    logic        hit;
    col_t        low_col;
    col_t        cand_col;

    always_ff @(posedge clk) begin
        if (local_srst) begin
            state <= s_reset;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            s_reset:   if (init_done) nxt_state = s_idle;
            s_idle:    nxt_state = s_rd_req;
            s_rd_req:  if (rd_gnt) nxt_state = s_rd_wait;
            s_rd_wait: if (rd_ack) nxt_state = s_check;
            s_check:   nxt_state = hit ? s_offer : s_next;
            s_next:    nxt_state = s_idle;
            // Recheck the same row after every take
            s_offer:   if (cand_take) nxt_state = s_check;
            default:   nxt_state = s_reset;
        endcase
    end

    // Row counter, wraps after the last row
    always_ff @(posedge clk) begin
        if (local_srst) begin
            row <= '0;
        end else if (state == s_next) begin
            row <= (row == row_t'(num_rows - 1)) ? '0 : row + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ack) begin
            row_copy <= rd_data;
        end else if (state == s_offer && cand_take) begin
            row_copy[cand_col] <= 1'b0;
        end
    end

    // Lowest free column
    always_comb begin
        hit     = 1'b0;
        low_col = '0;
        for (int c = 0; c < num_cols; c++) begin
            if (row_copy[c] && !hit) begin
                hit     = 1'b1;
                low_col = col_t'(c);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_check) begin
            cand_col <= low_col;
        end
    end

    assign rd_req     = (state == s_rd_req);
    assign rd_row     = row;
    assign cand_valid = (state == s_offer);
    assign cand.row   = row;
    assign cand.col   = cand_col;

endmodule : free_scanner

/* hdl/bitmap_ram.sv */
// Bit-vector RAM with init sweep and two-client read port, updater first
`timescale 1ns/1ps

module bitmap_ram (
    input  logic                    clk,
    input  logic                    local_srst,
    output logic                    init_done,
    input  logic                    upd_rd_req,
    input  ptr_alloc_pkg::row_t     upd_rd_row,
    output logic                    upd_rd_gnt,
    output logic                    upd_rd_ack,
    input  logic                    scan_rd_req,
    input  ptr_alloc_pkg::row_t     scan_rd_row,
    output logic                    scan_rd_gnt,
    output logic                    scan_rd_ack,
    output ptr_alloc_pkg::row_vec_t rd_data,
    input  logic                    wr_req,
    input  ptr_alloc_pkg::row_t     wr_row,
    input  ptr_alloc_pkg::row_vec_t wr_data
);
    import ptr_alloc_pkg::*;

    row_vec_t   mem [num_rows];
    row_t       init_row;
    row_t       rd_row;
    rd_client_t rd_tag_in;
    rd_client_t rd_tag;

    // ------------------------------
    // Init sweep
    // ------------------------------
    always_ff @(posedge clk) begin
        if (local_srst) begin
            init_row  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_row <= init_row + 1'b1;
            if (init_row == row_t'(num_rows - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // Sweep owns the write port until done
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[init_row] <= '1;
        end else if (wr_req) begin
            mem[wr_row] <= wr_data;
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------
    assign upd_rd_gnt  = upd_rd_req;
    assign scan_rd_gnt = scan_rd_req && !upd_rd_req;
    assign rd_row      = upd_rd_req ? upd_rd_row : scan_rd_row;

    assign rd_tag_in.valid = upd_rd_gnt || scan_rd_gnt;
    assign rd_tag_in.scan  = scan_rd_gnt;

    always_ff @(posedge clk) begin
        if (rd_tag_in.valid) begin
            rd_data <= mem[rd_row];
        end
    end

    // Tag follows the data by one cycle
    always_ff @(posedge clk) begin
        if (local_srst) begin
            rd_tag <= '0;
        end else begin
            rd_tag <= rd_tag_in;
        end
    end

    assign upd_rd_ack  = rd_tag.valid && !rd_tag.scan;
    assign scan_rd_ack = rd_tag.valid && rd_tag.scan;

    a_no_early_write: assert property (@(posedge clk) disable iff (local_srst)
        wr_req |-> init_done)
        else $error("bitmap write before init sweep finished");

endmodule : bitmap_ram

/* hdl/ptr_fifo.sv */
// Synchronous first-word-fall-through pointer queue with valid/ready on both sides
`timescale 1ns/1ps

module ptr_fifo #(
    parameter int fifo_depth = 32
) (
    input  logic                clk,
    input  logic                local_srst,
    input  logic                in_valid,
    input  ptr_alloc_pkg::ptr_t in_data,
    output logic                in_ready,
    output logic                out_valid,
    output ptr_alloc_pkg::ptr_t out_data,
    input  logic                out_ready
);
    import ptr_alloc_pkg::*;

    localparam int idx_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);

    ptr_t             mem [fifo_depth];
    logic [idx_w-1:0] wr_idx;
    logic [idx_w-1:0] rd_idx;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != cnt_w'(fifo_depth));
    assign out_valid = (count != '0);
    // Head word is always presented
    assign out_data  = mem[rd_idx];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_idx] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (local_srst) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_idx <= (wr_idx == idx_w'(fifo_depth - 1)) ? '0 : wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= (rd_idx == idx_w'(fifo_depth - 1)) ? '0 : rd_idx + 1'b1;
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

    // A full queue has wrapped its write index onto the head
    a_full_idx: assert property (@(posedge clk) disable iff (local_srst)
        (count == cnt_w'(fifo_depth)) |-> (wr_idx == rd_idx))
        else $error("ptr_fifo indices apart while full");

    // Word written into an empty queue shows at the head next cycle
    a_fwft_head: assert property (@(posedge clk) disable iff (local_srst)
        (count == '0 && push) |=> (out_valid && out_data == $past(in_data)))
        else $error("ptr_fifo head missed a word written while empty");

endmodule : ptr_fifo

/* hdl/ptr_alloc_pkg.sv */
// Pool geometry, pointer types, RAM read tag and error report struct
package ptr_alloc_pkg;

    // ------------------------------
    // Pool geometry
    // ------------------------------
    localparam int num_rows = 16;
    localparam int num_cols = 16;
    localparam int num_ptrs = num_rows * num_cols;

    // ------------------------------
    // Pointer types
    // ------------------------------
    typedef logic [$clog2(num_rows)-1:0] row_t;
    typedef logic [$clog2(num_cols)-1:0] col_t;
    typedef logic [$clog2(num_ptrs)-1:0] ptr_t;

    // Row in the upper bits, so the pattern matches ptr_t
    typedef struct packed {
        row_t row;
        col_t col;
    } ptr_addr_t;

    // One RAM word, bit c set when column c is free
    typedef logic [num_cols-1:0] row_vec_t;

    // Tag carried alongside a RAM read
    typedef struct packed {
        logic valid;
        logic scan;
    } rd_client_t;

    typedef struct packed {
        logic alloc_err;
        logic dealloc_err;
        ptr_t ptr;
    } err_report_t;

endpackage : ptr_alloc_pkg
